//--- addr_filter.f
+incdir+.
addr_filter_pkg.sv
axi_fifo.sv
wr_router.sv
rd_router.sv
b_rsp_merge.sv
addr_filter.sv
tb_addr_filter.sv

//--- tb_addr_filter_cases.svh
// case table for the filter testbench, included inside tb_addr_filter
// expected routes are written out by hand from the window bounds

`ifndef TB_ADDR_FILTER_CASES_SVH
`define TB_ADDR_FILTER_CASES_SVH

// each row holds is_read, id, addr, len, data seed and expected route
// reads ignore the data seed
typedef struct {
  bit                is_read;
  logic [ID_W-1:0]   id;
  logic [ADDR_W-1:0] addr;
  logic [7:0]        len;
  logic [DATA_W-1:0] seed;
  route_t            route;
} tcase_t;

localparam int NUM_CASES = 20;

tcase_t cases [NUM_CASES];

task automatic load_cases();
  // pipeline 0 and pipeline 1 edges and interior
  cases[0]  = '{1'b0, 4'h1, 64'h0000_0000_8000_0000, 8'd0, 32'h1000_0000, ROUTE_DP};
  cases[1]  = '{1'b0, 4'h2, 64'h0000_0000_FFFF_FFC0, 8'd3, 32'h2000_0000, ROUTE_DP};
  cases[2]  = '{1'b0, 4'h3, 64'h0000_0008_8000_0000, 8'd1, 32'h3000_0000, ROUTE_DP};
  cases[3]  = '{1'b0, 4'h4, 64'h0000_0009_FFFF_FFF0, 8'd2, 32'h4000_0000, ROUTE_DP};
  // single and multi-beat msi writes
  cases[4]  = '{1'b0, 4'h5, 64'h0000_0000_2001_8000, 8'd0, 32'h5000_0000, ROUTE_MSI};
  cases[5]  = '{1'b0, 4'h6, 64'h0000_0000_2001_8040, 8'd3, 32'h6000_0000, ROUTE_MSI};
  cases[6]  = '{1'b0, 4'h7, 64'h0000_0000_2001_807C, 8'd1, 32'h7000_0000, ROUTE_MSI};
  // just below pipeline 0 then a burst that must arrive intact
  cases[7]  = '{1'b0, 4'h8, 64'h0000_0000_7FFF_FFFF, 8'd2, 32'h8000_0000, ROUTE_DROP};
  cases[8]  = '{1'b0, 4'h9, 64'h0000_0000_8000_1000, 8'd1, 32'h9000_0000, ROUTE_DP};
  // just above msi then the last msi address
  cases[9]  = '{1'b0, 4'hA, 64'h0000_0000_2001_8080, 8'd3, 32'hA000_0000, ROUTE_DROP};
  cases[10] = '{1'b0, 4'hB, 64'h0000_0000_2001_807F, 8'd0, 32'hB000_0000, ROUTE_MSI};
  // gap between the pipeline windows
  cases[11] = '{1'b0, 4'hC, 64'h0000_0001_0000_0000, 8'd0, 32'hC000_0000, ROUTE_DROP};
  cases[12] = '{1'b0, 4'hD, 64'h0000_0008_7FFF_FFFF, 8'd1, 32'hD000_0000, ROUTE_DROP};
  // reads
  cases[13] = '{1'b1, 4'hD, 64'h0000_0008_8000_1000, 8'd3, 32'h0, ROUTE_DP};
  cases[14] = '{1'b1, 4'hE, 64'h0000_0000_2001_8010, 8'd0, 32'h0, ROUTE_MSI};
  cases[15] = '{1'b1, 4'hF, 64'h0000_0000_0000_1000, 8'd1, 32'h0, ROUTE_DROP};
  cases[16] = '{1'b1, 4'h0, 64'h0000_000A_0000_0000, 8'd0, 32'h0, ROUTE_DROP};
  cases[17] = '{1'b1, 4'h1, 64'h0000_0000_C000_0000, 8'd7, 32'h0, ROUTE_DP};
  cases[18] = '{1'b1, 4'h2, 64'h0000_0000_2001_7FFF, 8'd0, 32'h0, ROUTE_DROP};
  // long burst into pipeline 1
  cases[19] = '{1'b0, 4'h2, 64'h0000_0009_0000_0000, 8'd7, 32'hE000_0000, ROUTE_DP};
endtask

`endif

//--- tb_addr_filter.sv
// testbench for the address filter with random egress readies and slave models
// dropped writes are expected to get no response at all
// every wait gives up after TIMEOUT cycles

`timescale 1ns/100ps

module tb_addr_filter
  import addr_filter_pkg::*;
();

  localparam int TIMEOUT = 2000;

  logic    clk;
  logic    rst;
  ax_req_t igr_aw, igr_ar, dp_aw, msi_aw, dp_ar, msi_ar;
  w_beat_t igr_w, dp_w, msi_w;
  b_rsp_t  igr_b, dp_b, msi_b;
  logic    igr_aw_valid, igr_aw_ready, igr_w_valid, igr_w_ready, igr_ar_valid, igr_ar_ready;
  logic    igr_b_valid, igr_b_ready;
  logic    dp_aw_valid, dp_aw_ready, dp_w_valid, dp_w_ready, dp_ar_valid, dp_ar_ready;
  logic    msi_aw_valid, msi_aw_ready, msi_w_valid, msi_w_ready, msi_ar_valid, msi_ar_ready;
  logic    dp_b_valid, dp_b_ready, msi_b_valid, msi_b_ready;

  integer      seed = 31381;
  logic [31:0] rnd;
  bit          stall = 1'b0;
  bit          hold_b = 1'b0;
  int          dp_b_done = 0;
  int          msi_b_done = 0;

  // expected traffic per egress channel in arrival order
  ax_req_t         exp_dp_aw[$], exp_msi_aw[$], exp_dp_ar[$], exp_msi_ar[$];
  w_beat_t         exp_dp_w[$], exp_msi_w[$];
  b_rsp_t          exp_b_dp[$], exp_b_msi[$];
  // slave side ids of open bursts and of responses still to hand back
  logic [ID_W-1:0] dp_open[$], msi_open[$], dp_b_q[$], msi_b_q[$];

  `include "tb_addr_filter_cases.svh"

  addr_filter dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------------------
  // failure reporting and compares
  task automatic report_fail(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_ax(input string name, input ax_req_t got, input ax_req_t exp);
    if (got !== exp)
      report_fail($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_w(input string name, input w_beat_t got, input w_beat_t exp);
    if (got !== exp)
      report_fail($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_b(input string name, input b_rsp_t got, input b_rsp_t exp);
    if (got !== exp)
      report_fail($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  // ------------------------------------------------------------
  // egress slave models driven on the falling edge
  always @(negedge clk) begin
    rnd = $random(seed);
    // the filter hands over address and first beat as one, so aw and w readies move together
    dp_aw_ready  = !stall && (rnd[0] | rnd[1]);
    dp_w_ready   = dp_aw_ready;
    msi_aw_ready = !stall && (rnd[2] | rnd[3]);
    msi_w_ready  = msi_aw_ready;
    dp_ar_ready  = !stall && (rnd[4] | rnd[5]);
    msi_ar_ready = !stall && (rnd[5] | rnd[6]);
    igr_b_ready  = !hold_b && (rnd[6] | rnd[7]);
    // resp 0 from the datapath, 1 from msi
    dp_b_valid   = (dp_b_q.size() > 0);
    dp_b.id      = dp_b_valid ? dp_b_q[0] : '0;
    dp_b.resp    = 2'b00;
    msi_b_valid  = (msi_b_q.size() > 0);
    msi_b.id     = msi_b_valid ? msi_b_q[0] : '0;
    msi_b.resp   = 2'b01;
  end

  // transfers seen at the rising edge
  always @(posedge clk) begin
    if (!rst) begin
      if (dp_aw_valid && dp_aw_ready) begin
        if (exp_dp_aw.size() == 0)
          report_fail("dp_aw transfer with no write routed to the datapath");
        check_ax("dp_aw", dp_aw, exp_dp_aw.pop_front());
        dp_open.push_back(dp_aw.id);
      end
      if (dp_w_valid && dp_w_ready) begin
        if (exp_dp_w.size() == 0)
          report_fail("dp_w beat with no write data routed to the datapath");
        check_w("dp_w", dp_w, exp_dp_w.pop_front());
        if (dp_w.last)
          dp_b_q.push_back(dp_open.pop_front());
      end
      if (msi_aw_valid && msi_aw_ready) begin
        if (exp_msi_aw.size() == 0)
          report_fail("msi_aw transfer with no write routed to msi");
        check_ax("msi_aw", msi_aw, exp_msi_aw.pop_front());
        msi_open.push_back(msi_aw.id);
      end
      if (msi_w_valid && msi_w_ready) begin
        if (exp_msi_w.size() == 0)
          report_fail("msi_w beat with no write data routed to msi");
        check_w("msi_w", msi_w, exp_msi_w.pop_front());
        if (msi_w.last)
          msi_b_q.push_back(msi_open.pop_front());
      end
      if (dp_ar_valid && dp_ar_ready) begin
        if (exp_dp_ar.size() == 0)
          report_fail("dp_ar transfer with no read routed to the datapath");
        check_ax("dp_ar", dp_ar, exp_dp_ar.pop_front());
      end
      if (msi_ar_valid && msi_ar_ready) begin
        if (exp_msi_ar.size() == 0)
          report_fail("msi_ar transfer with no read routed to msi");
        check_ax("msi_ar", msi_ar, exp_msi_ar.pop_front());
      end
      if (dp_b_valid && dp_b_ready) begin
        void'(dp_b_q.pop_front());
        dp_b_done++;
      end
      if (msi_b_valid && msi_b_ready) begin
        void'(msi_b_q.pop_front());
        msi_b_done++;
      end
      // per-slave order is kept but the two slaves may interleave
      if (igr_b_valid && igr_b_ready) begin
        if (exp_b_msi.size() > 0 && igr_b === exp_b_msi[0]) begin
          void'(exp_b_msi.pop_front());
        end else if (exp_b_dp.size() == 0) begin
          report_fail("igr_b response that matches no outstanding write");
        end else begin
          check_b("igr_b", igr_b, exp_b_dp.pop_front());
        end
      end
    end
  end

  // ------------------------------------------------------------
  // ingress drivers called on the falling edge
  task automatic send_aw(input ax_req_t a);
    int t;
    t = 0;
    igr_aw = a;
    igr_aw_valid = 1'b1;
    while (!igr_aw_ready) begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT)
        report_fail("timeout while waiting for igr_aw_ready");
    end
    @(negedge clk);
    igr_aw_valid = 1'b0;
  endtask

  task automatic send_w(input w_beat_t b);
    int t;
    t = 0;
    igr_w = b;
    igr_w_valid = 1'b1;
    while (!igr_w_ready) begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT)
        report_fail("timeout while waiting for igr_w_ready");
    end
    @(negedge clk);
    igr_w_valid = 1'b0;
  endtask

  task automatic send_ar(input ax_req_t a);
    int t;
    t = 0;
    igr_ar = a;
    igr_ar_valid = 1'b1;
    while (!igr_ar_ready) begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT)
        report_fail("timeout while waiting for igr_ar_ready");
    end
    @(negedge clk);
    igr_ar_valid = 1'b0;
  endtask

  task automatic write_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                             input logic [7:0] len, input logic [DATA_W-1:0] dseed,
                             input route_t route);
    ax_req_t a;
    w_beat_t b;
    a = '{id: id, addr: addr, len: len, size: 3'd2, burst: 2'b01};
    if (route == ROUTE_DP) begin
      exp_dp_aw.push_back(a);
      exp_b_dp.push_back('{id: id, resp: 2'b00});
    end else if (route == ROUTE_MSI) begin
      exp_msi_aw.push_back(a);
      exp_b_msi.push_back('{id: id, resp: 2'b01});
    end
    send_aw(a);
    for (int i = 0; i <= len; i++) begin
      b = '{data: dseed + i, strb: '1, last: (i == len)};
      if (route == ROUTE_DP)
        exp_dp_w.push_back(b);
      else if (route == ROUTE_MSI)
        exp_msi_w.push_back(b);
      send_w(b);
    end
  endtask

  task automatic read_addr(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                           input logic [7:0] len, input route_t route);
    ax_req_t a;
    a = '{id: id, addr: addr, len: len, size: 3'd2, burst: 2'b01};
    if (route == ROUTE_DP)
      exp_dp_ar.push_back(a);
    else if (route == ROUTE_MSI)
      exp_msi_ar.push_back(a);
    send_ar(a);
  endtask

  task automatic wait_drained(input string phase);
    int t;
    t = 0;
    while (exp_dp_aw.size() + exp_msi_aw.size() + exp_dp_w.size() + exp_msi_w.size() +
           exp_dp_ar.size() + exp_msi_ar.size() + exp_b_dp.size() + exp_b_msi.size() != 0) begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT)
        report_fail({"timeout with expected traffic still outstanding after ", phase});
    end
    // quiet window where a stray transfer is still caught
    repeat (20) @(negedge clk);
  endtask

  // ------------------------------------------------------------
  // main sequence
  initial begin
    int t;
    int accepted;
    int dp_base;
    int msi_base;
    rst = 1'b1;
    igr_aw = '0;
    igr_aw_valid = 1'b0;
    igr_w = '0;
    igr_w_valid = 1'b0;
    igr_ar = '0;
    igr_ar_valid = 1'b0;
    igr_b_ready = 1'b0;
    {dp_aw_ready, dp_w_ready, dp_ar_ready, msi_aw_ready, msi_w_ready, msi_ar_ready} = '0;
    dp_b = '0;
    dp_b_valid = 1'b0;
    msi_b = '0;
    msi_b_valid = 1'b0;
    load_cases();

    // readies and valids stay low through reset
    repeat (3) begin
      @(posedge clk);
      @(negedge clk);
      if (igr_aw_ready || igr_w_ready || igr_ar_ready || dp_b_ready || msi_b_ready)
        report_fail("a ready output was high during reset");
      if (dp_aw_valid || dp_w_valid || dp_ar_valid || msi_aw_valid || msi_w_valid ||
          msi_ar_valid || igr_b_valid)
        report_fail("a valid output was high during reset");
    end
    rst = 1'b0;

    for (int n = 0; n < NUM_CASES; n++) begin
      if (cases[n].is_read)
        read_addr(cases[n].id, cases[n].addr, cases[n].len, cases[n].route);
      else
        write_burst(cases[n].id, cases[n].addr, cases[n].len, cases[n].seed, cases[n].route);
    end
    wait_drained("the case table");

    // msi response presented first when both are buffered
    hold_b = 1'b1;
    dp_base = dp_b_done;
    msi_base = msi_b_done;
    write_burst(4'h5, 64'h0000_0000_9000_0000, 8'd1, 32'h5500_0000, ROUTE_DP);
    write_burst(4'h9, 64'h0000_0000_2001_8020, 8'd0, 32'h9900_0000, ROUTE_MSI);
    t = 0;
    while (dp_b_done == dp_base || msi_b_done == msi_base) begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT)
        report_fail("timeout while waiting for both slaves to hand over a write response");
    end
    @(negedge clk);
    if (!igr_b_valid)
      report_fail("igr_b_valid is low with two buffered write responses");
    check_b("igr_b", igr_b, '{id: 4'h9, resp: 2'b01});
    hold_b = 1'b0;
    wait_drained("the response priority check");

    // back-pressure with egress stalled until ingress ready drops
    stall = 1'b1;
    @(negedge clk);
    accepted = 0;
    while (accepted < WR_FIFO_DEPTH && igr_aw_ready && igr_w_ready) begin
      igr_aw = '{id: accepted[ID_W-1:0], addr: 64'h8000_0000 + accepted * 64'h40,
                 len: 8'd0, size: 3'd2, burst: 2'b01};
      igr_w = '{data: 32'hB000_0000 + accepted, strb: '1, last: 1'b1};
      exp_dp_aw.push_back(igr_aw);
      exp_dp_w.push_back(igr_w);
      exp_b_dp.push_back('{id: igr_aw.id, resp: 2'b00});
      igr_aw_valid = 1'b1;
      igr_w_valid = 1'b1;
      accepted++;
      @(negedge clk);
      igr_aw_valid = 1'b0;
      igr_w_valid = 1'b0;
    end
    if (igr_aw_ready)
      report_fail($sformatf("igr_aw_ready still high after %0d stalled writes", accepted));
    stall = 1'b0;
    wait_drained("the back-pressure release");

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- addr_filter.sv
// axi address filter between one ingress master and the datapath and msi slaves
// aw, w and ar payloads are shared by both egress sets and only the valids differ
// requests outside every window are discarded without a response

`timescale 1ns/100ps

module addr_filter
  import addr_filter_pkg::*;
(
  input  var logic    clk
 ,input  var logic    rst

  // ingress
 ,input  var ax_req_t igr_aw
 ,input  var logic    igr_aw_valid
 ,output var logic    igr_aw_ready
 ,input  var w_beat_t igr_w
 ,input  var logic    igr_w_valid
 ,output var logic    igr_w_ready
 ,output var b_rsp_t  igr_b
 ,output var logic    igr_b_valid
 ,input  var logic    igr_b_ready
 ,input  var ax_req_t igr_ar
 ,input  var logic    igr_ar_valid
 ,output var logic    igr_ar_ready

  // datapath egress
 ,output var ax_req_t dp_aw
 ,output var logic    dp_aw_valid
 ,input  var logic    dp_aw_ready
 ,output var w_beat_t dp_w
 ,output var logic    dp_w_valid
 ,input  var logic    dp_w_ready
 ,input  var b_rsp_t  dp_b
 ,input  var logic    dp_b_valid
 ,output var logic    dp_b_ready
 ,output var ax_req_t dp_ar
 ,output var logic    dp_ar_valid
 ,input  var logic    dp_ar_ready

  // msi egress
 ,output var ax_req_t msi_aw
 ,output var logic    msi_aw_valid
 ,input  var logic    msi_aw_ready
 ,output var w_beat_t msi_w
 ,output var logic    msi_w_valid
 ,input  var logic    msi_w_ready
 ,input  var b_rsp_t  msi_b
 ,input  var logic    msi_b_valid
 ,output var logic    msi_b_ready
 ,output var ax_req_t msi_ar
 ,output var logic    msi_ar_valid
 ,input  var logic    msi_ar_ready
);

  ax_req_t egr_aw;
  w_beat_t egr_w;
  ax_req_t egr_ar;

  // ------------------------------------------------------------
  // shared fifo heads fan out to both slaves
  assign dp_aw  = egr_aw;
  assign msi_aw = egr_aw;
  assign dp_w   = egr_w;
  assign msi_w  = egr_w;
  assign dp_ar  = egr_ar;
  assign msi_ar = egr_ar;

  wr_router u_wr_router (
    .clk          (clk),
    .rst          (rst),
    .igr_aw       (igr_aw),
    .igr_aw_valid (igr_aw_valid),
    .igr_aw_ready (igr_aw_ready),
    .igr_w        (igr_w),
    .igr_w_valid  (igr_w_valid),
    .igr_w_ready  (igr_w_ready),
    .egr_aw       (egr_aw),
    .egr_w        (egr_w),
    .dp_aw_valid  (dp_aw_valid),
    .dp_w_valid   (dp_w_valid),
    .msi_aw_valid (msi_aw_valid),
    .msi_w_valid  (msi_w_valid),
    .dp_aw_ready  (dp_aw_ready),
    .dp_w_ready   (dp_w_ready),
    .msi_aw_ready (msi_aw_ready),
    .msi_w_ready  (msi_w_ready)
  );

  rd_router u_rd_router (
    .clk          (clk),
    .rst          (rst),
    .igr_ar       (igr_ar),
    .igr_ar_valid (igr_ar_valid),
    .igr_ar_ready (igr_ar_ready),
    .egr_ar       (egr_ar),
    .dp_ar_valid  (dp_ar_valid),
    .msi_ar_valid (msi_ar_valid),
    .dp_ar_ready  (dp_ar_ready),
    .msi_ar_ready (msi_ar_ready)
  );

  b_rsp_merge u_b_rsp_merge (
    .clk         (clk),
    .rst         (rst),
    .dp_b        (dp_b),
    .dp_b_valid  (dp_b_valid),
    .dp_b_ready  (dp_b_ready),
    .msi_b       (msi_b),
    .msi_b_valid (msi_b_valid),
    .msi_b_ready (msi_b_ready),
    .igr_b       (igr_b),
    .igr_b_valid (igr_b_valid),
    .igr_b_ready (igr_b_ready)
  );

endmodule

//--- b_rsp_merge.sv
// write response merge from both slaves onto the ingress B channel
// msi responses win whenever one is buffered
// slave readies are registered from each fifo's fill level

`timescale 1ns/100ps

module b_rsp_merge
  import addr_filter_pkg::*;
(
  input  var logic   clk
 ,input  var logic   rst
 ,input  var b_rsp_t dp_b
 ,input  var logic   dp_b_valid
 ,output var logic   dp_b_ready
 ,input  var b_rsp_t msi_b
 ,input  var logic   msi_b_valid
 ,output var logic   msi_b_ready
 ,output var b_rsp_t igr_b
 ,output var logic   igr_b_valid
 ,input  var logic   igr_b_ready
);

  b_rsp_t dp_head;
  b_rsp_t msi_head;
  logic   dp_empty;
  logic   msi_empty;
  logic   dp_pop;
  logic   msi_pop;

  // ------------------------------------------------------------
  // per-slave response buffers
  axi_fifo #(
    .payload_t (b_rsp_t),
    .DEPTH     (RSP_FIFO_DEPTH),
    .SLACK     (RSP_FIFO_SLACK)
  ) u_dp_fifo (
    .clk        (clk),
    .rst        (rst),
    .push_data  (dp_b),
    .push_valid (dp_b_valid),
    .push_ready (dp_b_ready),
    .pop_data   (dp_head),
    .empty      (dp_empty),
    .pop        (dp_pop)
  );

  axi_fifo #(
    .payload_t (b_rsp_t),
    .DEPTH     (RSP_FIFO_DEPTH),
    .SLACK     (RSP_FIFO_SLACK)
  ) u_msi_fifo (
    .clk        (clk),
    .rst        (rst),
    .push_data  (msi_b),
    .push_valid (msi_b_valid),
    .push_ready (msi_b_ready),
    .pop_data   (msi_head),
    .empty      (msi_empty),
    .pop        (msi_pop)
  );

  // ------------------------------------------------------------
  // datapath head only when no msi response waits
  assign igr_b_valid = !msi_empty || !dp_empty;
  assign igr_b       = msi_empty ? dp_head : msi_head;
  assign msi_pop     = !msi_empty && igr_b_ready;
  assign dp_pop      = msi_empty && !dp_empty && igr_b_ready;

endmodule

//--- rd_router.sv
// read address routing by window; out-of-range reads pop at once and vanish
// read data does not pass through this block

`timescale 1ns/100ps

module rd_router
  import addr_filter_pkg::*;
(
  input  var logic    clk
 ,input  var logic    rst
 ,input  var ax_req_t igr_ar
 ,input  var logic    igr_ar_valid
 ,output var logic    igr_ar_ready
 ,output var ax_req_t egr_ar
 ,output var logic    dp_ar_valid
 ,output var logic    msi_ar_valid
 ,input  var logic    dp_ar_ready
 ,input  var logic    msi_ar_ready
);

  logic   ar_empty;
  logic   ar_pop;
  route_t ar_route;

  axi_fifo #(
    .payload_t (ax_req_t),
    .DEPTH     (RD_FIFO_DEPTH),
    .SLACK     (RD_FIFO_SLACK)
  ) u_ar_fifo (
    .clk        (clk),
    .rst        (rst),
    .push_data  (igr_ar),
    .push_valid (igr_ar_valid),
    .push_ready (igr_ar_ready),
    .pop_data   (egr_ar),
    .empty      (ar_empty),
    .pop        (ar_pop)
  );

  assign ar_route     = decode_route(egr_ar.addr);
  assign dp_ar_valid  = !ar_empty && (ar_route == ROUTE_DP);
  assign msi_ar_valid = !ar_empty && (ar_route == ROUTE_MSI);

  // pop on the chosen slave's ready, or straight away when dropped
  assign ar_pop = (dp_ar_valid && dp_ar_ready) ||
                  (msi_ar_valid && msi_ar_ready) ||
                  (!ar_empty && (ar_route == ROUTE_DROP));

endmodule

//--- wr_router.sv
// write address and data routing; a burst starts only when both heads are present
// address and first beat leave together, later beats follow the held route
// dropped bursts are flushed one beat per cycle with no response

`timescale 1ns/100ps

module wr_router
  import addr_filter_pkg::*;
(
  input  var logic    clk
 ,input  var logic    rst
 ,input  var ax_req_t igr_aw
 ,input  var logic    igr_aw_valid
 ,output var logic    igr_aw_ready
 ,input  var w_beat_t igr_w
 ,input  var logic    igr_w_valid
 ,output var logic    igr_w_ready
 ,output var ax_req_t egr_aw
 ,output var w_beat_t egr_w
 ,output var logic    dp_aw_valid
 ,output var logic    dp_w_valid
 ,output var logic    msi_aw_valid
 ,output var logic    msi_w_valid
 ,input  var logic    dp_aw_ready
 ,input  var logic    dp_w_ready
 ,input  var logic    msi_aw_ready
 ,input  var logic    msi_w_ready
);

  logic   aw_empty;
  logic   w_empty;
  logic   aw_pop;
  logic   w_pop;
  logic   burst_pending;
  logic   burst_start;
  route_t start_route;
  route_t held_route;

  // ------------------------------------------------------------
  // ingress buffers
  axi_fifo #(
    .payload_t (ax_req_t),
    .DEPTH     (WR_FIFO_DEPTH),
    .SLACK     (WR_FIFO_SLACK)
  ) u_aw_fifo (
    .clk        (clk),
    .rst        (rst),
    .push_data  (igr_aw),
    .push_valid (igr_aw_valid),
    .push_ready (igr_aw_ready),
    .pop_data   (egr_aw),
    .empty      (aw_empty),
    .pop        (aw_pop)
  );

  axi_fifo #(
    .payload_t (w_beat_t),
    .DEPTH     (WR_FIFO_DEPTH),
    .SLACK     (WR_FIFO_SLACK)
  ) u_w_fifo (
    .clk        (clk),
    .rst        (rst),
    .push_data  (igr_w),
    .push_valid (igr_w_valid),
    .push_ready (igr_w_ready),
    .pop_data   (egr_w),
    .empty      (w_empty),
    .pop        (w_pop)
  );

  // ------------------------------------------------------------
  // route selection
  assign start_route = decode_route(egr_aw.addr);
  assign burst_start = !aw_empty && !w_empty && !burst_pending;

  always_comb begin
    dp_aw_valid  = 1'b0;
    dp_w_valid   = 1'b0;
    msi_aw_valid = 1'b0;
    msi_w_valid  = 1'b0;
    aw_pop       = 1'b0;
    w_pop        = 1'b0;
    if (burst_start) begin
      // address plus first beat popped together
      case (start_route)
        ROUTE_DP: begin
          dp_aw_valid = 1'b1;
          dp_w_valid  = 1'b1;
          aw_pop      = dp_aw_ready & dp_w_ready;
        end
        ROUTE_MSI: begin
          msi_aw_valid = 1'b1;
          msi_w_valid  = 1'b1;
          aw_pop       = msi_aw_ready & msi_w_ready;
        end
        default: aw_pop = 1'b1;
      endcase
      w_pop = aw_pop;
    end else if (burst_pending && !w_empty) begin
      // remaining beats of the open burst
      case (held_route)
        ROUTE_DP: begin
          dp_w_valid = 1'b1;
          w_pop      = dp_w_ready;
        end
        ROUTE_MSI: begin
          msi_w_valid = 1'b1;
          w_pop       = msi_w_ready;
        end
        default: w_pop = 1'b1;
      endcase
    end
  end

  // burst tracking
  always_ff @(posedge clk) begin
    if (rst) begin
      burst_pending <= 1'b0;
      held_route    <= ROUTE_DROP;
    end else begin
      if (aw_pop) begin
        held_route <= start_route;
      end
      if (w_pop) begin
        burst_pending <= !egr_w.last;
      end
    end
  end

  // a start that is not taken keeps presenting the same address and first beat
  a_start_held : assert property (
    @(posedge clk) disable iff (rst)
    burst_start && !aw_pop |=> burst_start && $stable(egr_aw) && $stable(egr_w)
  );

endmodule

//--- axi_fifo.sv
// show-ahead synchronous fifo whose head is valid whenever empty is low
// push_ready is registered from the fill level; SLACK must cover its one-cycle lag
// DEPTH of at least 2; pointers wrap explicitly so any depth works

`timescale 1ns/100ps

module axi_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 16,
  parameter int  SLACK     = 4
) (
  input  var logic     clk
 ,input  var logic     rst
 ,input  var payload_t push_data
 ,input  var logic     push_valid
 ,output var logic     push_ready
 ,output var payload_t pop_data
 ,output var logic     empty
 ,input  var logic     pop
);

  payload_t mem [DEPTH];

  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       do_push;

  assign do_push  = push_valid & push_ready;
  assign empty    = (count == '0);
  assign pop_data = mem[rd_ptr];

  // storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // pointers, fill level and registered ready
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      push_ready <= 1'b0;
    end else begin
      push_ready <= (count < DEPTH - SLACK);
      if (do_push) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ------------------------------------------------------------
  // checks
  // the registered ready with its slack must stop pushes before overflow
  a_no_overflow : assert property (
    @(posedge clk) disable iff (rst)
    do_push |-> (count < DEPTH)
  );

  // the consumer must only pop a valid head
  a_no_underflow : assert property (
    @(posedge clk) disable iff (rst)
    pop |-> !empty
  );

endmodule

//--- addr_filter_pkg.sv
// shared widths, fifo sizes, address windows and payload types for the filter
// window bounds are inclusive; pipeline windows are checked before the msi window
// lock, cache and prot fields are not carried

package addr_filter_pkg;

  // ------------------------------------------------------------
  // widths and depths
  localparam int ID_W   = 4;
  localparam int ADDR_W = 64;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // ready drops once the fill level reaches depth - slack
  localparam int WR_FIFO_DEPTH  = 16;
  localparam int WR_FIFO_SLACK  = 4;
  localparam int RD_FIFO_DEPTH  = 8;
  localparam int RD_FIFO_SLACK  = 3;
  localparam int RSP_FIFO_DEPTH = 8;
  localparam int RSP_FIFO_SLACK = 3;

  // ------------------------------------------------------------
  // address windows
  localparam logic [ADDR_W-1:0] PIPE0_START = 64'h0000_0000_8000_0000;
  localparam logic [ADDR_W-1:0] PIPE0_END   = 64'h0000_0000_FFFF_FFFF;
  localparam logic [ADDR_W-1:0] PIPE1_START = 64'h0000_0008_8000_0000;
  localparam logic [ADDR_W-1:0] PIPE1_END   = 64'h0000_0009_FFFF_FFFF;
  localparam logic [ADDR_W-1:0] MSI_START   = 64'h0000_0000_2001_8000;
  localparam logic [ADDR_W-1:0] MSI_END     = 64'h0000_0000_2001_807F;

  // ------------------------------------------------------------
  // payloads
  // shared by write and read address channels
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
  } ax_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w_beat_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } b_rsp_t;

  typedef enum logic [1:0] {
    ROUTE_DP,
    ROUTE_MSI,
    ROUTE_DROP
  } route_t;

  // window match; anything outside all three is dropped
  function automatic route_t decode_route(input logic [ADDR_W-1:0] addr);
    route_t route;
    if ((addr >= PIPE0_START && addr <= PIPE0_END) ||
        (addr >= PIPE1_START && addr <= PIPE1_END)) begin
      route = ROUTE_DP;
    end else if (addr >= MSI_START && addr <= MSI_END) begin
      route = ROUTE_MSI;
    end else begin
      route = ROUTE_DROP;
    end
    return route;
  endfunction

endpackage
